//--- common/div_cfg.svh
// Divider width, iteration count, latency and register map
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// ====================
// Datapath
// ====================
`define DIV_XLEN    32
`define DIV_STEPS   16
`define DIV_LATENCY 18

// ====================
// Register map
// ====================
`define DIV_ADDR_W       5
`define DIV_REG_DIVIDEND 5'h00
`define DIV_REG_DIVISOR  5'h04
`define DIV_REG_CTRL     5'h08
`define DIV_REG_RESULT   5'h0C
`define DIV_REG_STATUS   5'h10

`endif

//--- common/div_pkg.sv
// Opcode and state enums, core request and response structs, AXI response codes
`include "div_cfg.svh"

package div_pkg;

	// Bit 1 selects signed, bit 0 selects remainder
	typedef enum logic [1:0] {
		DIVU = 2'd0,
		REMU = 2'd1,
		DIV  = 2'd2,
		REM  = 2'd3
	} div_op_e;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		ITER,
		FINISH
	} div_state_e;

	typedef struct packed {
		div_op_e              op;
		logic [`DIV_XLEN-1:0] dividend;
		logic [`DIV_XLEN-1:0] divisor;
	} div_req_t;

	typedef struct packed {
		logic [`DIV_XLEN-1:0] result;
	} div_rsp_t;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

endpackage

//--- hw/div_cmd_in.sv
// AXI4-Lite write channels, operand registers and divider launch
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_cmd_in (
	input  logic                     clk_i,
	input  logic                     rst_n_i,

	// AW, W and B channels
	input  logic [`DIV_ADDR_W-1:0]   s_awaddr_i,
	input  logic                     s_awvalid_i,
	output logic                     s_awready_o,
	input  logic [`DIV_XLEN-1:0]     s_wdata_i,
	input  logic [`DIV_XLEN/8-1:0]   s_wstrb_i,
	input  logic                     s_wvalid_i,
	output logic                     s_wready_o,
	output logic [1:0]               s_bresp_o,
	output logic                     s_bvalid_o,
	input  logic                     s_bready_i,

	// Core side
	input  logic                     busy_i,
	output logic                     start_o,
	output div_pkg::div_req_t        req_o,
	output logic [`DIV_XLEN-1:0]     dividend_o,
	output logic [`DIV_XLEN-1:0]     divisor_o
);
	import div_pkg::*;

	logic                 wr_hs;
	logic                 wr_full;
	logic                 wr_err;
	logic                 wr_commit;
	logic                 bvalid_q;
	axi_resp_e            bresp_q;
	logic [`DIV_XLEN-1:0] dividend_q;
	logic [`DIV_XLEN-1:0] divisor_q;

	// ====================
	// Address and data acceptance
	// ====================

	// Both channels are taken together, and only with no B response waiting
	assign wr_hs       = s_awvalid_i & s_wvalid_i & ~bvalid_q;
	assign s_awready_o = wr_hs;
	assign s_wready_o  = wr_hs;

	assign wr_full = (s_wstrb_i == '1);

	always_comb begin
		case (s_awaddr_i)
			`DIV_REG_DIVIDEND,
			`DIV_REG_DIVISOR,
			`DIV_REG_CTRL: wr_err = busy_i;
			default:       wr_err = 1'b1;
		endcase
	end

	// Partial writes get OKAY but leave the registers alone
	assign wr_commit = wr_hs & ~wr_err & wr_full;

	// ====================
	// Operand registers
	// ====================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			dividend_q <= '0;
			divisor_q  <= '0;
		end else if (wr_commit) begin
			if (s_awaddr_i == `DIV_REG_DIVIDEND)
				dividend_q <= s_wdata_i;
			if (s_awaddr_i == `DIV_REG_DIVISOR)
				divisor_q <= s_wdata_i;
		end
	end

	assign dividend_o = dividend_q;
	assign divisor_o  = divisor_q;

	// Launch in the acceptance cycle, opcode taken straight from the write data
	assign start_o = wr_commit & (s_awaddr_i == `DIV_REG_CTRL);

	always_comb begin
		req_o.op       = div_op_e'(s_wdata_i[1:0]);
		req_o.dividend = dividend_q;
		req_o.divisor  = divisor_q;
	end

	// ====================
	// Write response
	// ====================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			bvalid_q <= 1'b0;
			bresp_q  <= OKAY;
		end else if (wr_hs) begin
			bvalid_q <= 1'b1;
			bresp_q  <= wr_err ? SLVERR : OKAY;
		end else if (s_bready_i) begin
			bvalid_q <= 1'b0;
		end
	end

	assign s_bvalid_o = bvalid_q;
	assign s_bresp_o  = bresp_q;

endmodule

//--- divider/div_core.sv
// Radix-4 restoring divider core with sign fix-up and RISC-V divide-by-zero rules
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_core (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              start_i,
	input  div_pkg::div_req_t req_i,
	output logic              busy_o,
	output logic              done_o,
	output div_pkg::div_rsp_t rsp_o
);
	import div_pkg::*;

	localparam int CNT_W = $clog2(`DIV_STEPS);

	div_state_e           state_q;
	logic [CNT_W-1:0]     cnt_q;

	// Request held for the whole division
	div_req_t             req_q;

	logic                 quo_neg_q;
	logic                 rem_neg_q;
	logic                 div_zero_q;
	logic [`DIV_XLEN-1:0] dvs_q;
	logic [`DIV_XLEN-1:0] quo_q;
	logic [`DIV_XLEN-1:0] rem_q;

	logic                 sign_a;
	logic                 sign_b;
	logic [`DIV_XLEN-1:0] abs_a;
	logic [`DIV_XLEN-1:0] abs_b;
	logic [`DIV_XLEN-1:0] rem_mid;
	logic [`DIV_XLEN-1:0] quo_mid;
	logic [`DIV_XLEN-1:0] rem_nxt;
	logic [`DIV_XLEN-1:0] quo_nxt;
	logic [`DIV_XLEN-1:0] quo_res;
	logic [`DIV_XLEN-1:0] rem_res;

	// One subtract-and-shift step. The top dividend bit moves into the
	// 33-bit shifted remainder, the trial bit comes back into the quotient
	function automatic void restore_step(
		input  logic [`DIV_XLEN-1:0] rem,
		input  logic [`DIV_XLEN-1:0] quo,
		input  logic [`DIV_XLEN-1:0] dvs,
		output logic [`DIV_XLEN-1:0] rem_out,
		output logic [`DIV_XLEN-1:0] quo_out
	);
		logic [`DIV_XLEN:0] shifted;
		logic [`DIV_XLEN:0] trial;
		shifted = {rem, quo[`DIV_XLEN-1]};
		trial   = shifted - {1'b0, dvs};
		if (trial[`DIV_XLEN]) begin
			// Negative, so keep the shifted remainder
			rem_out = shifted[`DIV_XLEN-1:0];
			quo_out = {quo[`DIV_XLEN-2:0], 1'b0};
		end else begin
			rem_out = trial[`DIV_XLEN-1:0];
			quo_out = {quo[`DIV_XLEN-2:0], 1'b1};
		end
	endfunction

	// ====================
	// Operand magnitudes
	// ====================
	assign sign_a = req_q.op[1] & req_q.dividend[`DIV_XLEN-1];
	assign sign_b = req_q.op[1] & req_q.divisor[`DIV_XLEN-1];
	assign abs_a  = sign_a ? -req_q.dividend : req_q.dividend;
	assign abs_b  = sign_b ? -req_q.divisor : req_q.divisor;

	// Two quotient bits per cycle
	always_comb begin
		restore_step(rem_q, quo_q, dvs_q, rem_mid, quo_mid);
		restore_step(rem_mid, quo_mid, dvs_q, rem_nxt, quo_nxt);
	end

	// ====================
	// Control FSM
	// ====================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start_i)
						state_q <= LOAD;
				end
				LOAD: begin
					state_q <= ITER;
					cnt_q   <= '0;
				end
				ITER: begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == CNT_W'(`DIV_STEPS - 1))
						state_q <= FINISH;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// ====================
	// Datapath
	// ====================
	always_ff @(posedge clk_i) begin
		if (state_q == IDLE && start_i)
			req_q <= req_i;
		if (state_q == LOAD) begin
			quo_neg_q  <= sign_a ^ sign_b;
			rem_neg_q  <= sign_a;
			div_zero_q <= (req_q.divisor == '0);
			quo_q      <= abs_a;
			dvs_q      <= abs_b;
			rem_q      <= '0;
		end
		if (state_q == ITER) begin
			quo_q <= quo_nxt;
			rem_q <= rem_nxt;
		end
	end

	// Sign fix-up; MIN / -1 already gives MIN with remainder zero here
	assign quo_res = quo_neg_q ? -quo_q : quo_q;
	assign rem_res = rem_neg_q ? -rem_q : rem_q;

	always_comb begin
		case (req_q.op)
			DIVU, DIV: rsp_o.result = div_zero_q ? '1 : quo_res;
			default:   rsp_o.result = div_zero_q ? req_q.dividend : rem_res;
		endcase
	end

	assign busy_o = (state_q != IDLE);
	assign done_o = (state_q == FINISH);

endmodule

//--- hw/div_rsp_out.sv
// AXI4-Lite read channels with result register, sticky done flag and read mux
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_rsp_out (
	input  logic                   clk_i,
	input  logic                   rst_n_i,

	// AR and R channels
	input  logic [`DIV_ADDR_W-1:0] s_araddr_i,
	input  logic                   s_arvalid_i,
	output logic                   s_arready_o,
	output logic [`DIV_XLEN-1:0]   s_rdata_o,
	output logic [1:0]             s_rresp_o,
	output logic                   s_rvalid_o,
	input  logic                   s_rready_i,

	// Core side
	input  logic                   busy_i,
	input  logic                   start_i,
	input  logic                   done_i,
	input  div_pkg::div_rsp_t      rsp_i,
	input  logic [`DIV_XLEN-1:0]   dividend_i,
	input  logic [`DIV_XLEN-1:0]   divisor_i
);
	import div_pkg::*;

	logic                 rd_hs;
	logic                 rvalid_q;
	axi_resp_e            rresp_q;
	logic [`DIV_XLEN-1:0] rdata_q;
	logic [`DIV_XLEN-1:0] result_q;
	logic                 done_q;
	logic [`DIV_XLEN-1:0] rd_data;
	axi_resp_e            rd_resp;

	// ====================
	// Result and status
	// ====================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			result_q <= '0;
			done_q   <= 1'b0;
		end else begin
			if (done_i)
				result_q <= rsp_i.result;
			if (start_i)
				done_q <= 1'b0;
			else if (done_i)
				done_q <= 1'b1;
		end
	end

	// Read decode, the finish cycle is already reported as done
	always_comb begin
		rd_data = '0;
		rd_resp = OKAY;
		case (s_araddr_i)
			`DIV_REG_DIVIDEND: rd_data = dividend_i;
			`DIV_REG_DIVISOR:  rd_data = divisor_i;
			`DIV_REG_RESULT:   rd_data = done_i ? rsp_i.result : result_q;
			`DIV_REG_STATUS: begin
				rd_data[0] = busy_i & ~done_i;
				rd_data[1] = done_q | done_i;
			end
			default: rd_resp = SLVERR;
		endcase
	end

	// ====================
	// Read response
	// ====================
	assign s_arready_o = ~rvalid_q;
	assign rd_hs       = s_arvalid_i & ~rvalid_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rvalid_q <= 1'b0;
			rresp_q  <= OKAY;
			rdata_q  <= '0;
		end else if (rd_hs) begin
			rvalid_q <= 1'b1;
			rresp_q  <= rd_resp;
			rdata_q  <= rd_data;
		end else if (s_rready_i) begin
			rvalid_q <= 1'b0;
		end
	end

	assign s_rvalid_o = rvalid_q;
	assign s_rresp_o  = rresp_q;
	assign s_rdata_o  = rdata_q;

endmodule

//--- hw/div_top.sv
// Divider top level with AXI4-Lite ports, write side, core and read side
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_top (
	input  logic                   clk_i,
	input  logic                   rst_n_i,

	input  logic [`DIV_ADDR_W-1:0] s_awaddr_i,
	input  logic                   s_awvalid_i,
	output logic                   s_awready_o,
	input  logic [`DIV_XLEN-1:0]   s_wdata_i,
	input  logic [`DIV_XLEN/8-1:0] s_wstrb_i,
	input  logic                   s_wvalid_i,
	output logic                   s_wready_o,
	output logic [1:0]             s_bresp_o,
	output logic                   s_bvalid_o,
	input  logic                   s_bready_i,

	input  logic [`DIV_ADDR_W-1:0] s_araddr_i,
	input  logic                   s_arvalid_i,
	output logic                   s_arready_o,
	output logic [`DIV_XLEN-1:0]   s_rdata_o,
	output logic [1:0]             s_rresp_o,
	output logic                   s_rvalid_o,
	input  logic                   s_rready_i
);
	import div_pkg::*;

	logic                 core_start;
	div_req_t             core_req;
	logic                 core_busy;
	logic                 core_done;
	div_rsp_t             core_rsp;
	logic [`DIV_XLEN-1:0] reg_dividend;
	logic [`DIV_XLEN-1:0] reg_divisor;

	div_cmd_in u_cmd_in (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.s_awaddr_i  (s_awaddr_i),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_wdata_i   (s_wdata_i),
		.s_wstrb_i   (s_wstrb_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_bresp_o   (s_bresp_o),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.busy_i      (core_busy),
		.start_o     (core_start),
		.req_o       (core_req),
		.dividend_o  (reg_dividend),
		.divisor_o   (reg_divisor)
	);

	div_core u_core (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.start_i (core_start),
		.req_i   (core_req),
		.busy_o  (core_busy),
		.done_o  (core_done),
		.rsp_o   (core_rsp)
	);

	div_rsp_out u_rsp_out (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.s_araddr_i  (s_araddr_i),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.busy_i      (core_busy),
		.start_i     (core_start),
		.done_i      (core_done),
		.rsp_i       (core_rsp),
		.dividend_i  (reg_dividend),
		.divisor_i   (reg_divisor)
	);

endmodule

//--- tb/div_checker.sv
// Concurrent assertions on the AXI responses, the core handshake and the core latency
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_checker (
	input logic                 clk_i,
	input logic                 rst_n_i,
	input logic                 bvalid_i,
	input logic                 bready_i,
	input logic [1:0]           bresp_i,
	input logic                 rvalid_i,
	input logic                 rready_i,
	input logic [`DIV_XLEN-1:0] rdata_i,
	input logic [1:0]           rresp_i,
	input logic                 start_i,
	input logic                 busy_i,
	input logic                 done_i
);
	int unsigned fail_count = 0;

	b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
	else begin
		fail_count++;
		$error("bvalid or bresp changed before bready");
	end

	r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
	else begin
		fail_count++;
		$error("rvalid, rdata or rresp changed before rready");
	end

	// Start only from idle, and the core goes busy right after it
	no_restart: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		start_i |=> busy_i && !$past(busy_i))
	else begin
		fail_count++;
		$error("core started while busy or did not go busy");
	end

	// Done lines up with the start pulse DIV_LATENCY cycles back
	latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_i == $past(start_i, `DIV_LATENCY))
	else begin
		fail_count++;
		$error("core done out of step with start");
	end

	reset_idle: assert property (@(posedge clk_i)
		!rst_n_i |=> !busy_i && !done_i && !bvalid_i && !rvalid_i)
	else begin
		fail_count++;
		$error("handshake or core status high after reset");
	end

endmodule

bind div_top div_checker u_checker (
	.clk_i    (clk_i),
	.rst_n_i  (rst_n_i),
	.bvalid_i (s_bvalid_o),
	.bready_i (s_bready_i),
	.bresp_i  (s_bresp_o),
	.rvalid_i (s_rvalid_o),
	.rready_i (s_rready_i),
	.rdata_i  (s_rdata_o),
	.rresp_i  (s_rresp_o),
	.start_i  (core_start),
	.busy_i   (core_busy),
	.done_i   (core_done)
);

//--- tb/div_tb.sv
// Divider testbench with AXI4-Lite tasks, LFSR stimulus, reference model, tests and watchdog
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_tb;
	import div_pkg::*;

	localparam int N_OPS  = 67;
	localparam int T_CLK  = 40;
	localparam int WD_CYC = 2 * N_OPS * (`DIV_LATENCY + 20) + 10;

	logic                   clk_i = 1'b0;
	logic                   rst_n_i;
	logic [`DIV_ADDR_W-1:0] s_awaddr_i;
	logic                   s_awvalid_i;
	logic                   s_awready_o;
	logic [`DIV_XLEN-1:0]   s_wdata_i;
	logic [`DIV_XLEN/8-1:0] s_wstrb_i;
	logic                   s_wvalid_i;
	logic                   s_wready_o;
	logic [1:0]             s_bresp_o;
	logic                   s_bvalid_o;
	logic                   s_bready_i;
	logic [`DIV_ADDR_W-1:0] s_araddr_i;
	logic                   s_arvalid_i;
	logic                   s_arready_o;
	logic [`DIV_XLEN-1:0]   s_rdata_o;
	logic [1:0]             s_rresp_o;
	logic                   s_rvalid_o;
	logic                   s_rready_i;

	int          err_cnt = 0;
	int          chk_cnt = 0;
	logic [31:0] lfsr_q  = 32'hf4f4_2abb;

	always #(T_CLK / 2) clk_i = ~clk_i;

	div_top UUT (.*);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// RISC-V M rules: truncating division, remainder takes the dividend's sign
	function automatic logic [31:0] ref_div(input div_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		logic [31:0] q;
		logic [31:0] r;
		if (b == 32'd0)
			return op[0] ? a : 32'hffff_ffff;
		if (op[1] && a == 32'h8000_0000 && b == 32'hffff_ffff)
			return op[0] ? 32'd0 : a;
		if (op[1]) begin
			q = $signed(a) / $signed(b);
			r = $signed(a) % $signed(b);
		end else begin
			q = a / b;
			r = a % b;
		end
		return op[0] ? r : q;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		chk_cnt++;
		assert (got === exp) else begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data,
			input int hold, output logic [1:0] resp);
		int n;
		s_awaddr_i  = addr;
		s_wdata_i   = data;
		s_wstrb_i   = '1;
		s_awvalid_i = 1'b1;
		s_wvalid_i  = 1'b1;
		n = 0;
		do begin
			@(negedge clk_i);
			n++;
		end while (!(s_awready_o && s_wready_o) && n < 50);
		if (!(s_awready_o && s_wready_o)) begin
			$display("Write to 0x%h was never accepted", addr);
			err_cnt++;
		end
		@(posedge clk_i);
		#2;
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		@(negedge clk_i);
		resp = s_bresp_o;
		if (!s_bvalid_o) begin
			$display("No write response for 0x%h", addr);
			err_cnt++;
		end
		// bready stays low for hold extra cycles
		repeat (hold + 1) @(posedge clk_i);
		#2;
		s_bready_i = 1'b1;
		@(posedge clk_i);
		#2;
		s_bready_i = 1'b0;
	endtask

	task automatic read_reg(input logic [4:0] addr, input int hold,
			output logic [31:0] data, output logic [1:0] resp);
		int n;
		s_araddr_i  = addr;
		s_arvalid_i = 1'b1;
		n = 0;
		do begin
			@(negedge clk_i);
			n++;
		end while (!s_arready_o && n < 50);
		if (!s_arready_o) begin
			$display("Read of 0x%h was never accepted", addr);
			err_cnt++;
		end
		@(posedge clk_i);
		#2;
		s_arvalid_i = 1'b0;
		@(negedge clk_i);
		data = s_rdata_o;
		resp = s_rresp_o;
		if (!s_rvalid_o) begin
			$display("No read response for 0x%h", addr);
			err_cnt++;
		end
		repeat (hold + 1) @(posedge clk_i);
		#2;
		s_rready_i = 1'b1;
		@(posedge clk_i);
		#2;
		s_rready_i = 1'b0;
	endtask

	task automatic launch(input div_op_e op, input logic [31:0] a, input logic [31:0] b,
			input int bhold);
		logic [1:0] resp;
		write_reg(`DIV_REG_DIVIDEND, a, 0, resp);
		check_value("s_bresp_o", resp, OKAY);
		write_reg(`DIV_REG_DIVISOR, b, 0, resp);
		check_value("s_bresp_o", resp, OKAY);
		write_reg(`DIV_REG_CTRL, {30'd0, op}, bhold, resp);
		check_value("s_bresp_o", resp, OKAY);
	endtask

	task automatic wait_done();
		logic [31:0] st;
		logic [1:0]  resp;
		int          n;
		n = 0;
		do begin
			read_reg(`DIV_REG_STATUS, 0, st, resp);
			n++;
		end while (!st[1] && n < 40);
		if (!st[1]) begin
			$display("Done never showed in the status register");
			err_cnt++;
		end
	endtask

	task automatic finish_check(input div_op_e op, input logic [31:0] a,
			input logic [31:0] b, input int rhold);
		logic [31:0] res;
		logic [1:0]  resp;
		wait_done();
		read_reg(`DIV_REG_RESULT, rhold, res, resp);
		check_value("s_rresp_o", resp, OKAY);
		check_value("s_rdata_o", res, ref_div(op, a, b));
	endtask

	task automatic run_op(input div_op_e op, input logic [31:0] a, input logic [31:0] b);
		launch(op, a, b, 0);
		finish_check(op, a, b, 0);
	endtask

	task automatic report_test(input string name, input int base);
		$display("%s: %0d errors", name, err_cnt - base);
	endtask

	initial begin
		#(WD_CYC * T_CLK);
		$display("Timeout: the tests did not finish in time");
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] d;
		logic [1:0]  resp;
		int          base;
		rst_n_i     = 1'b0;
		s_awaddr_i  = '0;
		s_awvalid_i = 1'b0;
		s_wdata_i   = '0;
		s_wstrb_i   = '0;
		s_wvalid_i  = 1'b0;
		s_bready_i  = 1'b0;
		s_araddr_i  = '0;
		s_arvalid_i = 1'b0;
		s_rready_i  = 1'b0;
		repeat (10) @(posedge clk_i);
		#2;
		rst_n_i = 1'b1;

		// ====================
		// Arithmetic
		// ====================
		base = err_cnt;
		for (int i = 0; i < 20; i++) begin
			a = rand_bits(32);
			b = rand_bits(i[0] ? 32 : 12);
			run_op(DIVU, a, b);
			run_op(REMU, a, b);
		end
		report_test("[1] unsigned division", base);

		// Each sign combination twice
		base = err_cnt;
		for (int i = 0; i < 8; i++) begin
			a = rand_bits(31);
			b = rand_bits(12) + 32'd1;
			if (i[1])
				a = -a;
			if (i[0])
				b = -b;
			run_op(DIV, a, b);
			run_op(REM, a, b);
		end
		report_test("[2] signed division", base);

		base = err_cnt;
		run_op(DIVU, 32'h1234_5678, 32'd0);
		run_op(REMU, 32'h1234_5678, 32'd0);
		run_op(DIV, 32'h8765_4321, 32'd0);
		run_op(REM, 32'h8765_4321, 32'd0);
		run_op(DIV, 32'h8000_0000, 32'hffff_ffff);
		run_op(REM, 32'h8000_0000, 32'hffff_ffff);
		run_op(DIVU, 32'd7, 32'd1000);
		run_op(REMU, 32'd7, 32'd1000);
		report_test("[3] special cases", base);

		// ====================
		// Bus behavior
		// ====================
		base = err_cnt;
		a = rand_bits(32);
		b = rand_bits(16);
		launch(DIVU, a, b, 0);
		write_reg(`DIV_REG_DIVISOR, 32'h0000_0003, 0, resp);
		check_value("s_bresp_o", resp, SLVERR);
		read_reg(`DIV_REG_DIVISOR, 0, d, resp);
		check_value("s_rdata_o", d, b);
		finish_check(DIVU, a, b, 0);
		report_test("[4] writes while busy", base);

		base = err_cnt;
		a = rand_bits(32);
		b = rand_bits(20);
		launch(REMU, a, b, 5);
		finish_check(REMU, a, b, 6);
		report_test("[5] back-pressure", base);

		base = err_cnt;
		a = rand_bits(32);
		b = rand_bits(8);
		launch(DIV, a, b, 0);
		read_reg(`DIV_REG_STATUS, 0, d, resp);
		check_value("s_rdata_o", d, 32'h1);
		wait_done();
		read_reg(`DIV_REG_STATUS, 0, d, resp);
		check_value("s_rdata_o", d, 32'h2);
		read_reg(5'h14, 0, d, resp);
		check_value("s_rresp_o", resp, SLVERR);
		check_value("s_rdata_o", d, 32'h0);
		write_reg(5'h14, 32'hdead_beef, 0, resp);
		check_value("s_bresp_o", resp, SLVERR);
		report_test("[6] status and unknown addresses", base);

		err_cnt += UUT.u_checker.fail_count;
		$display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- all.f
+incdir+common
common/div_pkg.sv
hw/div_cmd_in.sv
divider/div_core.sv
hw/div_rsp_out.sv
hw/div_top.sv
tb/div_checker.sv
tb/div_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module div_tb \
	-f all.f -Mdir "$OBJ" -o div_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Keep running after an assertion error so the testbench can report
"$OBJ/div_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0
